//--- dcache.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_lookup.sv
design/dcache_data_array.sv
design/dcache_bus_unit.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_sva.sv
test/dcache_tb.sv

//--- design/dcache_bus_unit.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_bus_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  dcache_pkg::main_state_e state,
    input  dcache_pkg::cpu_req_t    req,
    input  logic                    victim_way,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        victim_tag,
    input  logic [`DC_WAYS-1:0]     way_hit,
    input  dcache_pkg::line_t       way0_line,
    input  dcache_pkg::line_t       way1_line,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  dcache_pkg::word_t       ret_data,
    output logic                    rd_req,
    output dcache_pkg::bus_addr_t   rd_addr,
    output dcache_pkg::bus_addr_t   wr_addr,
    output dcache_pkg::line_t       wr_data,
    output dcache_pkg::strb_t       wr_wstrb,
    output dcache_pkg::bank_t       refill_bank,
    output logic                    refill_done,
    output dcache_pkg::word_t       rdata
);

    dcache_pkg::word_t hit_word;

    // returned word counter, words come back in order 0..3
    always_ff @(posedge clk) begin
        if (reset) begin
            refill_bank <= '0;
        end else if (state != dcache_pkg::MAIN_REFILL) begin
            refill_bank <= '0;
        end else if (ret_valid) begin
            refill_bank <= refill_bank + 1'b1;
        end
    end

    assign refill_done = (state == dcache_pkg::MAIN_REFILL) && ret_valid && ret_last;

    assign rd_req   = (state == dcache_pkg::MAIN_REPLACE);
    assign rd_addr  = {req.tag, req.index, {`DC_OFFSET_W{1'b0}}};
    assign wr_addr  = {victim_tag, req.index, {`DC_OFFSET_W{1'b0}}};
    assign wr_data  = victim_way ? way1_line : way0_line;
    assign wr_wstrb = {(`DC_WORD_W/8){victim_dirty}};   // whole line on writeback

    assign hit_word = way_hit[1] ? way1_line[`DC_WORD_W*req.offset[3:2] +: `DC_WORD_W]
                                 : way0_line[`DC_WORD_W*req.offset[3:2] +: `DC_WORD_W];

    always_comb begin
        case (state)
            dcache_pkg::MAIN_LOOKUP: rdata = hit_word;
            dcache_pkg::MAIN_REFILL: rdata = ret_data;   // critical word straight through
            default:                 rdata = '0;
        endcase
    end

endmodule

//--- design/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    valid,
    input  logic                    op,
    input  dcache_pkg::tag_t        tag,
    input  dcache_pkg::index_t      index,
    input  dcache_pkg::offset_t     offset,
    input  dcache_pkg::strb_t       wstrb,
    input  dcache_pkg::word_t       wdata,
    input  logic [`DC_WAYS-1:0]     way_hit,
    input  logic [`DC_WAYS-1:0]     way_valid,
    input  dcache_pkg::bank_t       refill_bank,
    input  logic                    refill_done,
    input  logic                    ret_valid,
    input  logic                    rd_rdy,
    input  logic                    wr_rdy,
    output logic                    addr_ok,
    output logic                    data_ok,
    output dcache_pkg::cpu_req_t    req,
    output dcache_pkg::main_state_e state,
    output dcache_pkg::wbuf_t       wbuf,
    output logic                    wbuf_valid,
    output dcache_pkg::index_t      read_index,
    output logic                    victim_way,
    output logic                    victim_dirty,
    output logic                    wr_req
);

    dcache_pkg::wbuf_state_e wbuf_state;
    logic [`DC_WAYS-1:0]     dirty [2**`DC_INDEX_W];
    logic [7:0]              lfsr;
    logic                    cache_hit;
    logic                    accept;
    logic                    store_hit;
    logic                    wbuf_conflict;
    logic                    raw_conflict;
    logic                    pick_way;
    logic                    pick_dirty;

    assign cache_hit = |way_hit;
    assign store_hit = (state == dcache_pkg::MAIN_LOOKUP) && cache_hit && req.op;

    // wbuf owns one bank this cycle
    assign wbuf_conflict = wbuf_valid && (wbuf.offset[3:2] == offset[3:2]);
    // load behind a store to the same bank would read stale data
    assign raw_conflict  = req.op && !op && (req.offset[3:2] == offset[3:2]);

    assign addr_ok = ((state == dcache_pkg::MAIN_IDLE) && !wbuf_conflict) ||
                     ((state == dcache_pkg::MAIN_LOOKUP) && cache_hit &&
                      !wbuf_conflict && !raw_conflict);
    assign accept  = valid && addr_ok;

    assign data_ok = ((state == dcache_pkg::MAIN_LOOKUP) && (cache_hit || req.op)) ||
                     ((state == dcache_pkg::MAIN_REFILL) && ret_valid && !req.op &&
                      (refill_bank == req.offset[3:2]));

    assign read_index = addr_ok ? index : req.index;
    assign wbuf_valid = (wbuf_state == dcache_pkg::WBUF_WRITE);

    // invalid way first, then random
    assign pick_way   = way_valid[0] ? (way_valid[1] ? lfsr[7] : 1'b1) : 1'b0;
    assign pick_dirty = way_valid[pick_way] && dirty[req.index][pick_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= dcache_pkg::MAIN_IDLE;
            victim_way   <= 1'b0;
            victim_dirty <= 1'b0;
            wr_req       <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::MAIN_IDLE: begin
                    if (accept) begin
                        state <= dcache_pkg::MAIN_LOOKUP;
                    end
                end
                dcache_pkg::MAIN_LOOKUP: begin
                    if (accept) begin
                        state <= dcache_pkg::MAIN_LOOKUP;
                    end else if (!cache_hit) begin
                        state <= dcache_pkg::MAIN_MISS;
                    end else begin
                        state <= dcache_pkg::MAIN_IDLE;
                    end
                end
                dcache_pkg::MAIN_MISS: begin
                    if (wr_rdy) begin
                        state        <= dcache_pkg::MAIN_REPLACE;
                        victim_way   <= pick_way;
                        victim_dirty <= pick_dirty;
                        wr_req       <= pick_dirty;   // single-cycle writeback
                    end
                end
                dcache_pkg::MAIN_REPLACE: begin
                    wr_req <= 1'b0;
                    if (rd_rdy) begin
                        state <= dcache_pkg::MAIN_REFILL;
                    end
                end
                dcache_pkg::MAIN_REFILL: begin
                    if (refill_done) begin
                        state <= dcache_pkg::MAIN_IDLE;
                    end
                end
                default: state <= dcache_pkg::MAIN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{op: op, tag: tag, index: index, offset: offset, wstrb: wstrb, wdata: wdata};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbuf_state <= dcache_pkg::WBUF_IDLE;
        end else if (store_hit) begin
            wbuf_state <= dcache_pkg::WBUF_WRITE;   // back-to-back store hits stay here
        end else begin
            wbuf_state <= dcache_pkg::WBUF_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wbuf <= '{way: way_hit[1], index: req.index, offset: req.offset,
                      wstrb: req.wstrb, wdata: req.wdata};
        end
    end

    // refill and the write buffer never overlap
    always_ff @(posedge clk) begin
        if (refill_done) begin
            dirty[req.index][victim_way] <= req.op;
        end else if (wbuf_valid) begin
            dirty[wbuf.index][wbuf.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= `DC_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6], lfsr[5] ^ lfsr[7], lfsr[4] ^ lfsr[7], lfsr[3] ^ lfsr[7],
                     lfsr[2:0], lfsr[7]};
        end
    end

endmodule

//--- design/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   read_index,
    input  dcache_pkg::wbuf_t    wbuf,
    input  logic                 wbuf_valid,
    input  logic                 refill_we,
    input  logic                 refill_way,
    input  dcache_pkg::bank_t    refill_bank,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::word_t    ret_data,
    output dcache_pkg::line_t    way0_line,
    output dcache_pkg::line_t    way1_line
);

    wire dcache_pkg::line_t way_line [`DC_WAYS];
    dcache_pkg::word_t      refill_word;
    logic                   store_word;

    // a store miss lands in its refill word
    assign store_word = req.op && (req.offset[3:2] == refill_bank);

    always_comb begin
        refill_word = ret_data;
        for (int i = 0; i < `DC_WORD_W/8; i++) begin
            if (store_word && req.wstrb[i]) begin
                refill_word[8*i +: 8] = req.wdata[8*i +: 8];
            end
        end
    end

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        for (genvar b = 0; b < `DC_BANKS; b++) begin : g_bank
            dcache_pkg::word_t  mem [2**`DC_INDEX_W];
            dcache_pkg::word_t  dout;
            dcache_pkg::word_t  din;
            dcache_pkg::index_t addr;
            dcache_pkg::strb_t  we;
            logic               wb_sel;
            logic               fill_sel;

            assign wb_sel   = wbuf_valid && (wbuf.way == 1'(w)) && (wbuf.offset[3:2] == 2'(b));
            assign fill_sel = refill_we && (refill_way == 1'(w)) && (refill_bank == 2'(b));

            assign addr = wb_sel ? wbuf.index : read_index;
            assign we   = wb_sel ? wbuf.wstrb : {(`DC_WORD_W/8){fill_sel}};
            assign din  = wb_sel ? wbuf.wdata : refill_word;

            always_ff @(posedge clk) begin
                for (int i = 0; i < `DC_WORD_W/8; i++) begin
                    if (we[i]) begin
                        mem[addr][8*i +: 8] <= din[8*i +: 8];
                    end
                end
                dout <= mem[addr];   // read-first
            end

            assign way_line[w][`DC_WORD_W*b +: `DC_WORD_W] = dout;
        end
    end

    assign way0_line = way_line[0];
    assign way1_line = way_line[1];

endmodule

//--- design/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split is tag | index | offset
`define DC_TAG_W      20
`define DC_INDEX_W    8
`define DC_OFFSET_W   4

// geometry
`define DC_WAYS       2
`define DC_BANKS      4      // words per line
`define DC_WORD_W     32
`define DC_LINE_W     128

// replacement lfsr start value
`define DC_LFSR_SEED  8'h01

`endif

//--- design/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]                           tag_t;
    typedef logic [`DC_INDEX_W-1:0]                         index_t;
    typedef logic [`DC_OFFSET_W-1:0]                        offset_t;
    typedef logic [$clog2(`DC_BANKS)-1:0]                   bank_t;
    typedef logic [`DC_WORD_W-1:0]                          word_t;
    typedef logic [`DC_WORD_W/8-1:0]                        strb_t;
    typedef logic [`DC_LINE_W-1:0]                          line_t;
    typedef logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0]  bus_addr_t;

    typedef enum logic [2:0] {
        MAIN_IDLE,
        MAIN_LOOKUP,
        MAIN_MISS,
        MAIN_REPLACE,
        MAIN_REFILL
    } main_state_e;

    typedef enum logic {
        WBUF_IDLE,
        WBUF_WRITE
    } wbuf_state_e;

    // accepted cpu request, held until lookup or refill ends
    typedef struct packed {
        logic    op;        // 1 = store
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    // pending store hit, written to one bank a cycle later
    typedef struct packed {
        logic    way;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } wbuf_t;

endpackage

//--- design/dcache_tag_lookup.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tag_lookup (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::index_t  read_index,
    input  dcache_pkg::tag_t    lookup_tag,
    input  logic                write_en,
    input  logic                write_way,
    input  dcache_pkg::index_t  write_index,
    input  dcache_pkg::tag_t    write_tag,
    output logic [`DC_WAYS-1:0] way_hit,
    output logic [`DC_WAYS-1:0] way_valid,
    output dcache_pkg::tag_t    victim_tag
);

    dcache_pkg::tag_t             tag_mem [`DC_WAYS][2**`DC_INDEX_W];
    dcache_pkg::tag_t             tag_q [`DC_WAYS];
    logic [2**`DC_INDEX_W-1:0]    valid_bits [`DC_WAYS];
    logic [`DC_WAYS-1:0]          valid_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_q[w] <= tag_mem[w][read_index];
        end
        if (write_en) begin
            tag_mem[write_way][write_index] <= write_tag;
        end
    end

    // valid bits sit in flops so reset can clear the whole cache
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '{default: '0};
            valid_q    <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= valid_bits[w][read_index];
            end
            if (write_en) begin
                valid_bits[write_way][write_index] <= 1'b1;
            end
        end
    end

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_cmp
        assign way_hit[w] = valid_q[w] && (tag_q[w] == lookup_tag);
    end

    assign way_valid  = valid_q;
    assign victim_tag = tag_q[write_way];   // write_way is the latched victim

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  logic                  op,
    input  dcache_pkg::tag_t      tag,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::offset_t   offset,
    input  dcache_pkg::strb_t     wstrb,
    input  dcache_pkg::word_t     wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output dcache_pkg::word_t     rdata,
    output logic                  rd_req,
    output dcache_pkg::bus_addr_t rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  dcache_pkg::word_t     ret_data,
    output logic                  wr_req,
    output dcache_pkg::bus_addr_t wr_addr,
    output dcache_pkg::strb_t     wr_wstrb,
    output dcache_pkg::line_t     wr_data,
    input  logic                  wr_rdy
);

    dcache_pkg::cpu_req_t    req;
    dcache_pkg::main_state_e state;
    dcache_pkg::wbuf_t       wbuf;
    dcache_pkg::index_t      read_index;
    dcache_pkg::bank_t       refill_bank;
    dcache_pkg::tag_t        victim_tag;
    dcache_pkg::line_t       way0_line;
    dcache_pkg::line_t       way1_line;
    logic [`DC_WAYS-1:0]     way_hit;
    logic [`DC_WAYS-1:0]     way_valid;
    logic                    wbuf_valid;
    logic                    victim_way;
    logic                    victim_dirty;
    logic                    refill_done;

    dcache_ctrl i_ctrl (
        .clk, .reset, .valid, .op, .tag, .index, .offset, .wstrb, .wdata,
        .way_hit, .way_valid, .refill_bank, .refill_done, .ret_valid, .rd_rdy, .wr_rdy,
        .addr_ok, .data_ok, .req, .state, .wbuf, .wbuf_valid, .read_index,
        .victim_way, .victim_dirty, .wr_req
    );

    // refill tag goes into the victim way, tagged valid on the last word
    dcache_tag_lookup i_tag_lookup (
        .clk, .reset, .read_index,
        .lookup_tag  (req.tag),
        .write_en    (refill_done),
        .write_way   (victim_way),
        .write_index (req.index),
        .write_tag   (req.tag),
        .way_hit, .way_valid, .victim_tag
    );

    dcache_data_array i_data_array (
        .clk, .read_index, .wbuf, .wbuf_valid,
        .refill_we  (ret_valid),   // memory returns words only during refill
        .refill_way (victim_way),
        .refill_bank, .req, .ret_data, .way0_line, .way1_line
    );

    dcache_bus_unit i_bus_unit (
        .clk, .reset, .state, .req, .victim_way, .victim_dirty, .victim_tag, .way_hit,
        .way0_line, .way1_line, .ret_valid, .ret_last, .ret_data,
        .rd_req, .rd_addr, .wr_addr, .wr_data, .wr_wstrb, .refill_bank, .refill_done, .rdata
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the dcache testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
    -f dcache.f -o dcache_sim > build.log 2>&1 \
    && ./obj_dir/dcache_sim > "$log" 2>&1 \
    || { cat build.log >> "$log"; echo "SIMULATION FAILED" >> "$log"; }

grep -q "SIMULATION FAILED" "$log" \
    && { echo "simulation failed, see $log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- test/dcache_sva.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    data_ok,
    input logic                    rd_req,
    input logic                    wr_req,
    input dcache_pkg::bus_addr_t   rd_addr,
    input dcache_pkg::main_state_e state
);

    // writeback has no handshake, so one cycle only
    a_wr_req_pulse: assert property (
        @(posedge clk) disable iff (reset) wr_req |=> !wr_req
    ) else $error("wr_req held high for more than one cycle");

    a_rd_addr_aligned: assert property (
        @(posedge clk) disable iff (reset) rd_req |-> (rd_addr[`DC_OFFSET_W-1:0] == '0)
    ) else $error("rd_addr not aligned to a line");

    // misses answer in lookup or refill only
    a_no_data_ok_waiting: assert property (
        @(posedge clk) disable iff (reset)
            !(data_ok && (state == dcache_pkg::MAIN_MISS || state == dcache_pkg::MAIN_REPLACE))
    ) else $error("data_ok raised while waiting on memory");

endmodule

bind dcache_top dcache_sva i_sva (
    .clk, .reset, .data_ok, .rd_req, .wr_req, .rd_addr, .state
);

//--- test/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb;

    localparam int NUM_REQS       = 1200;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 60;   // worst miss path stays well below this
    localparam int RESET_CYCLES   = 5;

    // one expected response, kept in acceptance order
    typedef struct packed {
        logic              op;
        dcache_pkg::word_t data;
        int                cycle;   // monitor cycle of acceptance
    } expect_t;

    logic                  clk       = 1'b0;
    logic                  reset     = 1'b1;
    logic                  valid     = 1'b0;
    logic                  op        = 1'b0;
    dcache_pkg::tag_t      tag       = '0;
    dcache_pkg::index_t    index     = '0;
    dcache_pkg::offset_t   offset    = '0;
    dcache_pkg::strb_t     wstrb     = '0;
    dcache_pkg::word_t     wdata     = '0;
    logic                  rd_rdy    = 1'b0;
    logic                  ret_valid = 1'b0;
    logic                  ret_last  = 1'b0;
    dcache_pkg::word_t     ret_data  = '0;
    logic                  wr_rdy    = 1'b0;
    logic                  addr_ok;
    logic                  data_ok;
    logic                  rd_req;
    logic                  wr_req;
    dcache_pkg::word_t     rdata;
    dcache_pkg::bus_addr_t rd_addr;
    dcache_pkg::bus_addr_t wr_addr;
    dcache_pkg::strb_t     wr_wstrb;
    dcache_pkg::line_t     wr_data;

    dcache_pkg::word_t     golden_mem [dcache_pkg::bus_addr_t];
    dcache_pkg::word_t     bus_mem [dcache_pkg::bus_addr_t];
    expect_t               exp_q [$];
    integer                seed = 40;
    int                    issued, accept_count, resp_count, load_count;
    int                    store_count, store_acks, wb_count, check_count;
    int                    reset_cycles, cycles, mon_cycles;
    int                    err_reset, err_load, err_store, err_wb, err_order;
    bit                    refill_active;
    dcache_pkg::bus_addr_t refill_addr;
    int                    refill_cnt;

    dcache_top i_dut (.*);

    always #4 clk = ~clk;

    // power-on memory contents
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::bus_addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic dcache_pkg::tag_t pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 20'h00003;
            2'd1:    return 20'h1a2b4;
            2'd2:    return 20'h7c0de;
            default: return 20'hf00f5;
        endcase
    endfunction

    function automatic dcache_pkg::index_t pick_index(input logic [1:0] sel);
        case (sel)
            2'd0:    return 8'h00;
            2'd1:    return 8'h01;
            2'd2:    return 8'h80;
            default: return 8'hff;
        endcase
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                      input dcache_pkg::word_t data,
                                                      input dcache_pkg::strb_t strb);
        dcache_pkg::word_t w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) w[8*i +: 8] = data[8*i +: 8];
        end
        return w;
    endfunction

    function automatic dcache_pkg::word_t golden_read(input dcache_pkg::bus_addr_t a);
        if (golden_mem.exists(a)) return golden_mem[a];
        return fill_word(a);
    endfunction

    function automatic dcache_pkg::word_t bus_read(input dcache_pkg::bus_addr_t a);
        if (bus_mem.exists(a)) return bus_mem[a];
        return fill_word(a);
    endfunction

    function automatic dcache_pkg::line_t golden_line(input dcache_pkg::bus_addr_t a);
        dcache_pkg::line_t l;
        for (int k = 0; k < `DC_BANKS; k++) begin
            l[32*k +: 32] = golden_read(a + 4 * k);   // word k sits in bank k
        end
        return l;
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp, inout int errs);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t exp, inout int errs);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_strb(input string name, input dcache_pkg::strb_t got,
                              input dcache_pkg::strb_t exp, inout int errs);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    // memory side, answers on the falling edge
    task automatic drive_bus();
        logic [31:0] r;
        r = $random(seed);
        rd_rdy    = !refill_active && (r[1:0] == 2'b00);
        wr_rdy    = (r[3:2] != 2'b00);
        ret_valid = refill_active && r[4];   // random gaps between words
        ret_last  = ret_valid && (refill_cnt == `DC_BANKS - 1);
        ret_data  = ret_valid ? bus_read(refill_addr + 4 * refill_cnt) : '0;
    endtask

    task automatic issue_request();
        logic [31:0] r;
        r = $random(seed);
        if (issued == NUM_REQS || r[15:14] == 2'b00) begin
            valid = 1'b0;   // idle cycle
        end else begin
            valid  = 1'b1;
            op     = r[0];
            tag    = pick_tag(r[2:1]);
            index  = pick_index(r[4:3]);
            offset = r[8:5];
            wstrb  = r[12:9];
            wdata  = $random(seed);
            issued++;
        end
    endtask

    task automatic take_request();
        expect_t               e;
        dcache_pkg::bus_addr_t a;
        a       = {tag, index, offset[3:2], 2'b00};
        e.op    = op;
        e.data  = golden_read(a);   // load sees memory as of acceptance
        e.cycle = mon_cycles;
        if (op) begin
            golden_mem[a] = merge_bytes(e.data, wdata, wstrb);
            store_count++;
        end
        exp_q.push_back(e);
        if (accept_count == 0) $display("test reset_quiet: %0d errors", err_reset);
        accept_count++;
    endtask

    task automatic take_response();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("data_ok at %0t with no request outstanding", $time);
            err_order++;
        end else begin
            e = exp_q.pop_front();
            resp_count++;
            if (e.op) begin
                store_acks++;
                check_count++;
                // a store answers in its lookup cycle, hit or miss
                if (mon_cycles != e.cycle + 1) begin
                    $display("store accepted in cycle %0d answered in cycle %0d at %0t",
                             e.cycle, mon_cycles, $time);
                    err_store++;
                end
            end else begin
                load_count++;
                check_word("rdata", rdata, e.data, err_load);
            end
        end
    endtask

    task automatic take_writeback();
        dcache_pkg::line_t exp_line;
        if (wr_addr[3:0] != 4'h0) begin
            $display("writeback address %h is not line aligned at %0t", wr_addr, $time);
            err_wb++;
        end
        exp_line = golden_line(wr_addr);
        check_strb("wr_wstrb", wr_wstrb, 4'hf, err_wb);
        check_line("wr_data", wr_data, exp_line, err_wb);
        for (int k = 0; k < `DC_BANKS; k++) begin
            bus_mem[wr_addr + 4 * k] = wr_data[32*k +: 32];
        end
        wb_count++;
    endtask

    always @(negedge clk) begin
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == RESET_CYCLES) reset = 1'b0;
        end else begin
            drive_bus();
            if (!valid || accept_count == issued) issue_request();
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            mon_cycles++;
            if (accept_count == 0 && (data_ok || rd_req || wr_req)) begin
                $display("bus or response active before the first request at %0t", $time);
                err_reset++;
            end
            if (data_ok) take_response();
            if (wr_req) take_writeback();
            if (rd_req && rd_addr[3:0] != 4'h0) begin
                $display("refill address %h is not line aligned at %0t", rd_addr, $time);
                err_order++;
            end
            if (ret_valid) begin
                refill_cnt++;
                if (refill_cnt == `DC_BANKS) refill_active = 1'b0;
            end
            if (rd_req && rd_rdy && !refill_active) begin
                refill_active = 1'b1;
                refill_addr   = rd_addr;
                refill_cnt    = 0;
            end
            if (valid && addr_ok) take_request();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, resp_count, NUM_REQS);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        wait (resp_count == NUM_REQS);
        @(negedge clk);
        check_count++;
        if (wb_count == 0) begin
            $display("no writeback happened during the run");
            err_wb++;
        end
        total = err_reset + err_load + err_store + err_wb + err_order;
        $display("test load_data: %0d loads checked, %0d errors", load_count, err_load);
        $display("test store_ack: %0d of %0d stores answered, %0d errors",
                 store_acks, store_count, err_store);
        $display("test writeback: %0d writebacks checked, %0d errors", wb_count, err_wb);
        $display("test response_order: %0d responses for %0d requests, %0d errors",
                 resp_count, accept_count, err_order);
        $display("counts: %0d checks, %0d errors", check_count, total);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
